//--- matchedFilter_config.svh
/* Matched filter configuration */
`ifndef MATCHED_FILTER_CONFIG_SVH
`define MATCHED_FILTER_CONFIG_SVH

// Width of one signed real input sample.
`define SAMPLE_WIDTH 12

// Hilbert filter length; the centre tap sits at index HT_TAPS / 2.
`define HT_TAPS 7
// Nonzero Hilbert coefficient magnitudes at one and three taps from the centre.
`define HT_COEFF_1 5
`define HT_COEFF_3 2

// Each part of a complex sample holds the Hilbert sum with no loss.
`define COMPLEX_WIDTH 20

// Complex FIR sizing.
`define COEFF_WIDTH 12
`define FIR_TAPS 8
`define ACC_WIDTH 40

// Depth of the sample buffer in complex words.
`define FIFO_DEPTH 16

`endif

//--- matchedFilterPkg.sv
/* Matched filter types */
`include "matchedFilter_config.svh"

package matchedFilterPkg;

	// A real input sample together with its strobe.
	typedef struct packed {
		logic valid;
		logic signed [`SAMPLE_WIDTH-1:0] data;
	} realSampleT;

	// An analytic sample as it leaves the Hilbert stage and sits in the buffer.
	typedef struct packed {
		logic signed [`COMPLEX_WIDTH-1:0] re;
		logic signed [`COMPLEX_WIDTH-1:0] im;
	} complexSampleT;

	// One tap of the complex impulse response.
	typedef struct packed {
		logic signed [`COEFF_WIDTH-1:0] re;
		logic signed [`COEFF_WIDTH-1:0] im;
	} complexCoeffT;

	// Full precision filter result with its strobe.
	typedef struct packed {
		logic valid;
		logic signed [`ACC_WIDTH-1:0] re;
		logic signed [`ACC_WIDTH-1:0] im;
	} filterOutT;

endpackage

//--- hilbertTransform.sv
/* Hilbert transform stage */
`include "matchedFilter_config.svh"

module hilbertTransform (
	input logic clock,
	input logic rstN,
	input matchedFilterPkg::realSampleT sampleIn,
	output logic htValid,
	output matchedFilterPkg::complexSampleT htSample
);

	// Index of the centre tap in the delay line.
	localparam int centre = `HT_TAPS / 2;

	// Coefficients held at the sum width so the products need no extension.
	localparam logic signed [`COMPLEX_WIDTH-1:0] coeff1 = `HT_COEFF_1;
	localparam logic signed [`COMPLEX_WIDTH-1:0] coeff3 = `HT_COEFF_3;

	// Real history, newest sample at index 0.
	logic signed [`SAMPLE_WIDTH-1:0] delayLine [`HT_TAPS];
	logic stage1Valid;

	logic signed [`COMPLEX_WIDTH-1:0] reNext;
	logic signed [`COMPLEX_WIDTH-1:0] imNext;

	// Stage 1 shifts the history, but only when a new sample arrives.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `HT_TAPS; i++) begin
				delayLine[i] <= '0;
			end
			stage1Valid <= 1'b0;
		end else begin
			stage1Valid <= sampleIn.valid;
			if (sampleIn.valid) begin
				for (int i = `HT_TAPS - 1; i > 0; i--) begin
					delayLine[i] <= delayLine[i-1];
				end
				delayLine[0] <= sampleIn.data;
			end
		end
	end

	// The real part is simply the centre tap, so it lines up with the filtered part.
	assign reNext = `COMPLEX_WIDTH'(delayLine[centre]);

	// The taps are odd-symmetric about the centre.
	// Pairing opposite taps halves the number of multiplies.
	// Index 0 carries minus HT_COEFF_3 and the last index carries plus HT_COEFF_3.
	assign imNext =
		coeff1 * (`COMPLEX_WIDTH'(delayLine[centre+1]) - `COMPLEX_WIDTH'(delayLine[centre-1])) +
		coeff3 * (`COMPLEX_WIDTH'(delayLine[centre+3]) - `COMPLEX_WIDTH'(delayLine[centre-3]));

	// Stage 2 strobe.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			htValid <= 1'b0;
		end else begin
			htValid <= stage1Valid;
		end
	end

	// Stage 2 data, only loaded when stage 1 holds a fresh sample.
	always_ff @(posedge clock) begin
		if (stage1Valid) begin
			htSample <= '{re: reNext, im: imNext};
		end
	end

	// The buffer counts every strobe, so an unknown one would corrupt its level.
	validKnown: assert property (
		@(posedge clock) disable iff (!rstN) !$isunknown(htValid)
	) else $error("htValid is unknown after reset");

endmodule

//--- sampleFifo.sv
/* Complex sample buffer */
`include "matchedFilter_config.svh"

module sampleFifo (
	input logic clock,
	input logic rstN,
	input logic push,
	input matchedFilterPkg::complexSampleT pushData,
	input logic pop,
	output matchedFilterPkg::complexSampleT fifoData,
	output logic fifoEmpty,
	output logic overflow
);

	localparam int ptrW = $clog2(`FIFO_DEPTH);
	localparam logic [ptrW:0] depthCount = (ptrW + 1)'(`FIFO_DEPTH);

	matchedFilterPkg::complexSampleT mem [`FIFO_DEPTH];
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	// One bit wider than the pointers, so a full buffer is distinct from an empty one.
	logic [ptrW:0] count;
	logic full;
	logic pushOk;

	assign full = (count == depthCount);
	assign fifoEmpty = (count == '0);
	// A push into a full buffer is lost even if a pop happens in the same cycle.
	assign pushOk = push && !full;

	// The head word is visible without a read request.
	assign fifoData = mem[rdPtr];

	always_ff @(posedge clock) begin
		if (pushOk) begin
			mem[wrPtr] <= pushData;
		end
	end

	// Pointers wrap on their own since the depth is a power of two.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (pushOk) begin
				wrPtr <= wrPtr + ptrW'(1);
			end
			if (pop) begin
				rdPtr <= rdPtr + ptrW'(1);
			end
			count <= count + (ptrW + 1)'(pushOk) - (ptrW + 1)'(pop);
			// Sticky until the next reset.
			if (push && full) begin
				overflow <= 1'b1;
			end
		end
	end

	// The consumer must look at fifoEmpty before it pops.
	noEmptyPop: assert property (
		@(posedge clock) disable iff (!rstN) pop |-> !fifoEmpty
	) else $error("Pop from an empty FIFO");

	// The count must never exceed the depth.
	countBound: assert property (
		@(posedge clock) disable iff (!rstN) count <= depthCount
	) else $error("FIFO count above its depth");

endmodule

//--- complexFir.sv
/* Complex FIR filter */
`include "matchedFilter_config.svh"

module complexFir (
	input logic clock,
	input logic rstN,
	input logic coeffLoad,
	input matchedFilterPkg::complexCoeffT coeffIn,
	input logic fifoEmpty,
	input matchedFilterPkg::complexSampleT fifoData,
	output logic pop,
	output logic coeffsReady,
	output matchedFilterPkg::filterOutT filterOut
);

	localparam int tapW = $clog2(`FIR_TAPS);
	localparam logic [tapW-1:0] lastTap = tapW'(`FIR_TAPS - 1);

	// Coefficient store, tap 0 first.
	matchedFilterPkg::complexCoeffT coeffs [`FIR_TAPS];
	logic [tapW-1:0] tapCount;

	// Complex data line, newest sample at index 0.
	matchedFilterPkg::complexSampleT dataLine [`FIR_TAPS];
	logic stage1Valid;

	logic signed [`ACC_WIDTH-1:0] accRe;
	logic signed [`ACC_WIDTH-1:0] accIm;
	logic outValid;
	logic signed [`ACC_WIDTH-1:0] outRe;
	logic signed [`ACC_WIDTH-1:0] outIm;

	// Loading phase. Pulses after the last tap has been stored have no effect.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			tapCount <= '0;
			coeffsReady <= 1'b0;
		end else if (coeffLoad && !coeffsReady) begin
			tapCount <= tapCount + tapW'(1);
			if (tapCount == lastTap) begin
				coeffsReady <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (coeffLoad && !coeffsReady) begin
			coeffs[tapCount] <= coeffIn;
		end
	end

	// Drain the buffer one sample per cycle once the taps are in place.
	assign pop = coeffsReady && !fifoEmpty;

	// Stage 1 moves the data line on every pop.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int k = 0; k < `FIR_TAPS; k++) begin
				dataLine[k] <= '0;
			end
			stage1Valid <= 1'b0;
		end else begin
			stage1Valid <= pop;
			if (pop) begin
				for (int k = `FIR_TAPS - 1; k > 0; k--) begin
					dataLine[k] <= dataLine[k-1];
				end
				dataLine[0] <= fifoData;
			end
		end
	end

	// Complex multiply-accumulate across all taps at full width.
	// Operands are sign-extended to the accumulator width first, so nothing overflows.
	always_comb begin
		accRe = '0;
		accIm = '0;
		for (int k = 0; k < `FIR_TAPS; k++) begin
			accRe = accRe
				+ `ACC_WIDTH'(coeffs[k].re) * `ACC_WIDTH'(dataLine[k].re)
				- `ACC_WIDTH'(coeffs[k].im) * `ACC_WIDTH'(dataLine[k].im);
			accIm = accIm
				+ `ACC_WIDTH'(coeffs[k].re) * `ACC_WIDTH'(dataLine[k].im)
				+ `ACC_WIDTH'(coeffs[k].im) * `ACC_WIDTH'(dataLine[k].re);
		end
	end

	// Stage 2 registers the sum.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= stage1Valid;
		end
	end

	always_ff @(posedge clock) begin
		if (stage1Valid) begin
			outRe <= accRe;
			outIm <= accIm;
		end
	end

	assign filterOut = '{valid: outValid, re: outRe, im: outIm};

	// Results are only meaningful after the full impulse response is loaded.
	validNeedsCoeffs: assert property (
		@(posedge clock) disable iff (!rstN) filterOut.valid |-> coeffsReady
	) else $error("Filter output valid before coefficients are ready");

endmodule

//--- matchedFilter.sv
/* Matched filter top */

module matchedFilter (
	input logic clock,
	input logic rstN,
	input matchedFilterPkg::realSampleT sampleIn,
	input logic coeffLoad,
	input matchedFilterPkg::complexCoeffT coeffIn,
	output matchedFilterPkg::filterOutT filterOut,
	output logic coeffsReady,
	output logic overflow
);

	// Hilbert stage to buffer.
	logic htValid;
	matchedFilterPkg::complexSampleT htSample;

	// Buffer to FIR.
	matchedFilterPkg::complexSampleT fifoData;
	logic fifoEmpty;
	logic pop;

	// Turns the real input into an analytic signal.
	hilbertTransform iHilbert (
		.clock(clock),
		.rstN(rstN),
		.sampleIn(sampleIn),
		.htValid(htValid),
		.htSample(htSample)
	);

	// Holds samples while the coefficients are still being loaded.
	// The producer is never stalled, so a full buffer drops samples.
	sampleFifo iFifo (
		.clock(clock),
		.rstN(rstN),
		.push(htValid),
		.pushData(htSample),
		.pop(pop),
		.fifoData(fifoData),
		.fifoEmpty(fifoEmpty),
		.overflow(overflow)
	);

	// Convolves the analytic samples with the complex impulse response.
	complexFir iFir (
		.clock(clock),
		.rstN(rstN),
		.coeffLoad(coeffLoad),
		.coeffIn(coeffIn),
		.fifoEmpty(fifoEmpty),
		.fifoData(fifoData),
		.pop(pop),
		.coeffsReady(coeffsReady),
		.filterOut(filterOut)
	);

endmodule

//--- tbMatchedFilter.sv
/* Matched filter testbench */
`include "matchedFilter_config.svh"

module tbMatchedFilter;

	localparam int maxStim = 64;
	localparam int timeoutCycles = 200;

	logic clock;
	logic rstN;
	matchedFilterPkg::realSampleT sampleIn;
	logic coeffLoad;
	matchedFilterPkg::complexCoeffT coeffIn;
	matchedFilterPkg::filterOutT filterOut;
	logic coeffsReady;
	logic overflow;

	// Input samples of the running test, plus the loaded and the rejected coefficient sets.
	logic signed [`SAMPLE_WIDTH-1:0] stim [maxStim];
	matchedFilterPkg::complexCoeffT coeffSet [`FIR_TAPS];
	matchedFilterPkg::complexCoeffT altSet [`FIR_TAPS];

	// Expected results in output order.
	matchedFilterPkg::filterOutT expQ [$];
	matchedFilterPkg::filterOutT expWord;
	int gotCount;
	int totalOutputs;
	int errors;
	int testErrors;

	matchedFilter i_dut (
		.clock(clock),
		.rstN(rstN),
		.sampleIn(sampleIn),
		.coeffLoad(coeffLoad),
		.coeffIn(coeffIn),
		.filterOut(filterOut),
		.coeffsReady(coeffsReady),
		.overflow(overflow)
	);

	always #4 clock = ~clock;

	// Input history with zeros before the first sample.
	function automatic longint histSample(int j);
		if (j < 0) begin
			return 0;
		end
		return longint'(stim[j]);
	endfunction

	// Analytic sample i: the real part is delayed to the centre tap.
	// Tap k of -c3, 0, -c1, 0, c1, 0, c3 weights the input x[i-k].
	function automatic matchedFilterPkg::complexSampleT refHilbert(int i);
		longint taps [`HT_TAPS];
		longint im;
		matchedFilterPkg::complexSampleT s;
		taps = '{-longint'(`HT_COEFF_3), 0, -longint'(`HT_COEFF_1), 0,
			longint'(`HT_COEFF_1), 0, longint'(`HT_COEFF_3)};
		im = 0;
		for (int k = 0; k < `HT_TAPS; k++) begin
			im += taps[k] * histSample(i - k);
		end
		s.re = `COMPLEX_WIDTH'(histSample(i - `HT_TAPS / 2));
		s.im = `COMPLEX_WIDTH'(im);
		return s;
	endfunction

	// Output i is the sum over k of coeff[k] times Hilbert output i-k.
	function automatic matchedFilterPkg::filterOutT refFir(int i);
		longint re;
		longint im;
		matchedFilterPkg::complexSampleT d;
		matchedFilterPkg::filterOutT r;
		re = 0;
		im = 0;
		for (int k = 0; k < `FIR_TAPS; k++) begin
			if (i - k >= 0) begin
				d = refHilbert(i - k);
				re += longint'(coeffSet[k].re) * longint'(d.re)
					- longint'(coeffSet[k].im) * longint'(d.im);
				im += longint'(coeffSet[k].re) * longint'(d.im)
					+ longint'(coeffSet[k].im) * longint'(d.re);
			end
		end
		r.valid = 1'b1;
		r.re = `ACC_WIDTH'(re);
		r.im = `ACC_WIDTH'(im);
		return r;
	endfunction

	// Outputs are taken at the falling edge, half a cycle after they change.
	always @(negedge clock) begin
		if (rstN && filterOut.valid) begin
			assert (expQ.size() > 0) else begin
				$display("An output appeared when no more outputs were expected");
				errors++;
			end
			if (expQ.size() > 0) begin
				expWord = expQ.pop_front();
				assert (filterOut.re === expWord.re) else begin
					$display("ERR filterOut.re: got %h expected %h", filterOut.re, expWord.re);
					errors++;
				end
				assert (filterOut.im === expWord.im) else begin
					$display("ERR filterOut.im: got %h expected %h", filterOut.im, expWord.im);
					errors++;
				end
			end
			gotCount++;
		end
	end

	task automatic resetDut();
		sampleIn <= '0;
		coeffLoad <= 1'b0;
		coeffIn <= '0;
		rstN <= 1'b0;
		repeat (16) @(posedge clock);
		expQ.delete();
		gotCount = 0;
		rstN <= 1'b1;
		@(posedge clock);
	endtask

	task automatic drawCoeffs();
		for (int k = 0; k < `FIR_TAPS; k++) begin
			coeffSet[k].re = `COEFF_WIDTH'($urandom);
			coeffSet[k].im = `COEFF_WIDTH'($urandom);
			altSet[k].re = `COEFF_WIDTH'($urandom);
			altSet[k].im = `COEFF_WIDTH'($urandom);
		end
	endtask

	task automatic drawSamples(int n);
		for (int i = 0; i < n; i++) begin
			stim[i] = `SAMPLE_WIDTH'($urandom);
		end
	endtask

	task automatic expectOutputs(int n);
		for (int i = 0; i < n; i++) begin
			expQ.push_back(refFir(i));
		end
	endtask

	// One pulse per tap, tap 0 first.
	task automatic loadCoeffs(bit alternate);
		for (int k = 0; k < `FIR_TAPS; k++) begin
			@(posedge clock);
			coeffLoad <= 1'b1;
			coeffIn <= alternate ? altSet[k] : coeffSet[k];
		end
		@(posedge clock);
		coeffLoad <= 1'b0;
	endtask

	// Back to back samples, one per clock.
	task automatic sendSamples(int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clock);
			sampleIn.valid <= 1'b1;
			sampleIn.data <= stim[i];
		end
		@(posedge clock);
		sampleIn.valid <= 1'b0;
	endtask

	task automatic waitOutputs(int n);
		int c;
		c = 0;
		while (gotCount < n && c < timeoutCycles) begin
			@(negedge clock);
			c++;
		end
		assert (gotCount >= n) else begin
			$display("Timed out after %0d of %0d outputs", gotCount, n);
			errors++;
		end
	endtask

	// Any output during this window is caught by the compare process.
	task automatic quietCycles(int n);
		for (int c = 0; c < n; c++) begin
			@(negedge clock);
		end
	endtask

	task automatic checkFlag(string name, logic got, logic exp);
		assert (got === exp) else begin
			$display("ERR %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report(int num, string name);
		$display("Test %0d %s: %0d outputs, %0d errors", num, name, gotCount,
			errors - testErrors);
		testErrors = errors;
		totalOutputs += gotCount;
	endtask

	initial begin
		clock = 1'b0;
		rstN = 1'b0;
		sampleIn = '0;
		coeffLoad = 1'b0;
		coeffIn = '0;
		gotCount = 0;
		totalOutputs = 0;
		errors = 0;
		testErrors = 0;
		void'($urandom(13));

		// A single unit pulse shows the Hilbert taps shaped by the coefficients.
		resetDut();
		drawCoeffs();
		for (int i = 0; i < 24; i++) begin
			stim[i] = (i == 0) ? `SAMPLE_WIDTH'(1) : '0;
		end
		expectOutputs(24);
		loadCoeffs(1'b0);
		sendSamples(24);
		waitOutputs(24);
		report(1, "impulse response");

		resetDut();
		drawCoeffs();
		drawSamples(64);
		expectOutputs(64);
		loadCoeffs(1'b0);
		sendSamples(64);
		waitOutputs(64);
		checkFlag("coeffsReady", coeffsReady, 1'b1);
		checkFlag("overflow", overflow, 1'b0);
		report(2, "random stream");

		// Samples wait in the FIFO until the last tap arrives.
		resetDut();
		drawCoeffs();
		drawSamples(10);
		expectOutputs(10);
		sendSamples(10);
		quietCycles(4);
		checkFlag("coeffsReady", coeffsReady, 1'b0);
		loadCoeffs(1'b0);
		waitOutputs(10);
		checkFlag("coeffsReady", coeffsReady, 1'b1);
		report(3, "samples before coefficients");

		// Only the first 16 samples fit, the rest are dropped.
		resetDut();
		drawCoeffs();
		drawSamples(20);
		expectOutputs(16);
		sendSamples(20);
		quietCycles(4);
		loadCoeffs(1'b0);
		waitOutputs(16);
		quietCycles(50);
		checkFlag("overflow", overflow, 1'b1);
		report(4, "overflow");

		resetDut();
		drawCoeffs();
		drawSamples(32);
		expectOutputs(32);
		loadCoeffs(1'b0);
		loadCoeffs(1'b1);
		sendSamples(32);
		waitOutputs(32);
		report(5, "coefficient reload ignored");

		resetDut();
		@(negedge clock);
		checkFlag("coeffsReady", coeffsReady, 1'b0);
		checkFlag("overflow", overflow, 1'b0);
		checkFlag("filterOut.valid", filterOut.valid, 1'b0);
		drawSamples(1);
		sendSamples(1);
		quietCycles(40);
		report(6, "reset state");

		$display("Tests 6, outputs %0d, errors %0d", totalOutputs, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- build.f
+incdir+.
matchedFilterPkg.sv
hilbertTransform.sv
sampleFifo.sv
complexFir.sv
matchedFilter.sv
tbMatchedFilter.sv

//--- run.sh
#!/bin/sh
# Compile the matched filter testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f build.f \
	--top-module tbMatchedFilter -o simMatchedFilter
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit 1
fi

output=$(./obj_dir/simMatchedFilter)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
	exit 0
fi
exit 1
